// File: hw/la_settings.svh
`ifndef LA_SETTINGS_SVH
`define LA_SETTINGS_SVH

`define LA_NUM_REGS         32

// 3R opcodes, inst[31:15]
`define LA_OP_ADD_W         17'h00020
`define LA_OP_SUB_W         17'h00022
`define LA_OP_SLT           17'h00024
`define LA_OP_SLTU          17'h00025
`define LA_OP_AND           17'h00029
`define LA_OP_OR            17'h0002a
`define LA_OP_XOR           17'h0002b

// 2RI12 opcodes, inst[31:22]
`define LA_OP_SLTI          10'h008
`define LA_OP_SLTUI         10'h009
`define LA_OP_ADDI_W        10'h00a
`define LA_OP_ANDI          10'h00d
`define LA_OP_ORI           10'h00e
`define LA_OP_XORI          10'h00f
`define LA_OP_LD_W          10'h0a2
`define LA_OP_ST_W          10'h0a6

// 1RI20 opcodes, inst[31:25]
`define LA_OP_LU12I_W       7'h0a
`define LA_OP_PCADDU12I     7'h0e

`define LA_ALUOP_ADD        8'h01
`define LA_ALUOP_SUB        8'h02
`define LA_ALUOP_SLT        8'h03
`define LA_ALUOP_SLTU       8'h04
`define LA_ALUOP_AND        8'h05
`define LA_ALUOP_OR         8'h06
`define LA_ALUOP_XOR        8'h07
`define LA_ALUOP_LD         8'h08
`define LA_ALUOP_ST         8'h09
`define LA_ALUOP_LUI        8'h0a
`define LA_ALUOP_PCADD      8'h0b

`define LA_ALUSEL_ARITH     3'd1
`define LA_ALUSEL_LOGIC     3'd2
`define LA_ALUSEL_MEM       3'd3
`define LA_ALUSEL_IMM       3'd4

`endif

// File: hw/la_pkg.sv
`default_nettype none

package la_pkg;

`include "la_settings.svh"

    typedef logic [31:0] word_t;                            // Data, pc or instruction
    typedef logic [$clog2(`LA_NUM_REGS)-1:0] reg_addr_t;
    typedef logic [7:0] aluop_t;
    typedef logic [2:0] alusel_t;

    // Verdict of one format decoder
    typedef struct packed {
        logic      hit;
        logic      reg_write_en;
        aluop_t    aluop;
        alusel_t   alusel;
        word_t     imm;
        logic      reg1_read_en;
        logic      reg2_read_en;
        reg_addr_t reg1_addr;
        reg_addr_t reg2_addr;
        reg_addr_t wr_addr;
    } dec_bus_t;

    typedef struct packed {
        logic      valid;
        logic      ine;                                     // Instruction not exist
        word_t     pc;
        word_t     inst;
        logic      reg_write_en;
        aluop_t    aluop;
        alusel_t   alusel;
        word_t     imm;
        logic      reg1_read_en;
        logic      reg2_read_en;
        reg_addr_t reg1_addr;
        reg_addr_t reg2_addr;
        reg_addr_t wr_addr;
        word_t     reg1_data;
        word_t     reg2_data;
        logic      pre_taken;
        word_t     pre_addr;
    } id_ex_t;

endpackage

`default_nettype wire

// File: hw/id_fmt_3r.sv
`timescale 1ns/1ns
`default_nettype none

`include "la_settings.svh"

module id_fmt_3r (
    input  la_pkg::word_t    inst,
    output la_pkg::dec_bus_t dec
);
    import la_pkg::*;

    logic    hit;
    aluop_t  aluop;
    alusel_t alusel;

    always_comb begin
        hit    = 1'b1;
        aluop  = '0;
        alusel = `LA_ALUSEL_ARITH;
        case (inst[31:15])
            `LA_OP_ADD_W: aluop = `LA_ALUOP_ADD;
            `LA_OP_SUB_W: aluop = `LA_ALUOP_SUB;
            `LA_OP_SLT:   aluop = `LA_ALUOP_SLT;
            `LA_OP_SLTU:  aluop = `LA_ALUOP_SLTU;
            `LA_OP_AND: begin
                aluop  = `LA_ALUOP_AND;
                alusel = `LA_ALUSEL_LOGIC;
            end
            `LA_OP_OR: begin
                aluop  = `LA_ALUOP_OR;
                alusel = `LA_ALUSEL_LOGIC;
            end
            `LA_OP_XOR: begin
                aluop  = `LA_ALUOP_XOR;
                alusel = `LA_ALUSEL_LOGIC;
            end
            default: hit = 1'b0;
        endcase
    end

    always_comb begin
        dec = '0;
        if (hit) begin
            dec.hit          = 1'b1;
            dec.reg_write_en = 1'b1;
            dec.aluop        = aluop;
            dec.alusel       = alusel;
            dec.reg1_read_en = 1'b1;
            dec.reg2_read_en = 1'b1;
            dec.reg1_addr    = inst[9:5];                   // rj
            dec.reg2_addr    = inst[14:10];                 // rk
            dec.wr_addr      = inst[4:0];                   // rd
        end
    end

endmodule

`default_nettype wire

// File: hw/id_fmt_2ri12.sv
`timescale 1ns/1ns
`default_nettype none

`include "la_settings.svh"

module id_fmt_2ri12 (
    input  la_pkg::word_t    inst,
    output la_pkg::dec_bus_t dec
);
    import la_pkg::*;

    logic [11:0] imm12;
    logic        hit;
    logic        zext;
    logic        store;
    aluop_t      aluop;
    alusel_t     alusel;

    assign imm12 = inst[21:10];

    always_comb begin
        hit    = 1'b1;
        zext   = 1'b0;
        store  = 1'b0;
        aluop  = '0;
        alusel = `LA_ALUSEL_ARITH;
        case (inst[31:22])
            `LA_OP_SLTI:   aluop = `LA_ALUOP_SLT;
            `LA_OP_SLTUI:  aluop = `LA_ALUOP_SLTU;
            `LA_OP_ADDI_W: aluop = `LA_ALUOP_ADD;
            `LA_OP_ANDI, `LA_OP_ORI, `LA_OP_XORI: begin
                zext   = 1'b1;                              // Logic ops take unsigned imm
                alusel = `LA_ALUSEL_LOGIC;
                case (inst[31:22])
                    `LA_OP_ANDI: aluop = `LA_ALUOP_AND;
                    `LA_OP_ORI:  aluop = `LA_ALUOP_OR;
                    default:     aluop = `LA_ALUOP_XOR;
                endcase
            end
            `LA_OP_LD_W: begin
                aluop  = `LA_ALUOP_LD;
                alusel = `LA_ALUSEL_MEM;
            end
            `LA_OP_ST_W: begin
                store  = 1'b1;
                aluop  = `LA_ALUOP_ST;
                alusel = `LA_ALUSEL_MEM;
            end
            default: hit = 1'b0;
        endcase
    end

    always_comb begin
        dec = '0;
        if (hit) begin
            dec.hit          = 1'b1;
            dec.reg_write_en = !store;
            dec.aluop        = aluop;
            dec.alusel       = alusel;
            dec.imm          = zext ? {20'b0, imm12} : {{20{imm12[11]}}, imm12};
            dec.reg1_read_en = 1'b1;
            dec.reg2_read_en = store;                       // Store data comes from rd
            dec.reg1_addr    = inst[9:5];
            dec.reg2_addr    = store ? inst[4:0] : '0;
            dec.wr_addr      = store ? '0 : inst[4:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/id_fmt_1ri20.sv
`timescale 1ns/1ns
`default_nettype none

`include "la_settings.svh"

module id_fmt_1ri20 (
    input  la_pkg::word_t    inst,
    output la_pkg::dec_bus_t dec
);
    import la_pkg::*;

    logic   hit;
    aluop_t aluop;

    always_comb begin
        hit   = 1'b1;
        aluop = '0;
        case (inst[31:25])
            `LA_OP_LU12I_W:   aluop = `LA_ALUOP_LUI;
            `LA_OP_PCADDU12I: aluop = `LA_ALUOP_PCADD;    // Execute adds pc
            default:          hit   = 1'b0;
        endcase
    end

    always_comb begin
        dec = '0;
        if (hit) begin
            dec.hit          = 1'b1;
            dec.reg_write_en = 1'b1;
            dec.aluop        = aluop;
            dec.alusel       = `LA_ALUSEL_IMM;
            dec.imm          = {inst[24:5], 12'b0};
            dec.wr_addr      = inst[4:0];
        end
    end

endmodule

`default_nettype wire

// File: hw/id.sv
`timescale 1ns/1ns
`default_nettype none

module id (
    input  logic             clk,                           // Checking only
    input  logic             arst_n,
    input  la_pkg::word_t    inst,
    output la_pkg::dec_bus_t dec,
    output logic             ine
);
    import la_pkg::*;

    dec_bus_t   dec_3r;
    dec_bus_t   dec_2ri12;
    dec_bus_t   dec_1ri20;
    logic [2:0] hits;

    id_fmt_3r id_fmt_3r_inst (
        .inst (inst),
        .dec  (dec_3r)
    );

    id_fmt_2ri12 id_fmt_2ri12_inst (
        .inst (inst),
        .dec  (dec_2ri12)
    );

    id_fmt_1ri20 id_fmt_1ri20_inst (
        .inst (inst),
        .dec  (dec_1ri20)
    );

    assign hits = {dec_1ri20.hit, dec_2ri12.hit, dec_3r.hit};

    always_comb begin
        case (hits)
            3'b001:  dec = dec_3r;
            3'b010:  dec = dec_2ri12;
            3'b100:  dec = dec_1ri20;
            default: dec = '0;
        endcase
    end

    assign ine = (hits == '0);                              // Nobody claims it

    // Opcode spaces of the three formats must not overlap
    assert property (@(posedge clk) disable iff (!arst_n) $onehot0(hits))
        else $error("id: more than one format decoder hit, hits=%b", hits);

endmodule

`default_nettype wire

// File: hw/regfile.sv
`timescale 1ns/1ns
`default_nettype none

`include "la_settings.svh"

module regfile (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              wb_en,
    input  la_pkg::reg_addr_t wb_addr,
    input  la_pkg::word_t     wb_data,
    input  logic              rd1_en,
    input  logic              rd2_en,
    input  la_pkg::reg_addr_t rd1_addr,
    input  la_pkg::reg_addr_t rd2_addr,
    output la_pkg::word_t     rd1_data,
    output la_pkg::word_t     rd2_data
);
    import la_pkg::*;

    word_t regs [`LA_NUM_REGS];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `LA_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en && wb_addr != '0) begin
            regs[wb_addr] <= wb_data;
        end
    end

    function automatic word_t read_port(input logic en, input reg_addr_t addr);
        word_t data;
        if (!en || addr == '0) begin
            data = '0;
        end else if (wb_en && wb_addr == addr) begin
            data = wb_data;                                 // Bypass same-cycle write
        end else begin
            data = regs[addr];
        end
        return data;
    endfunction

    always_comb begin
        rd1_data = read_port(rd1_en, rd1_addr);
        rd2_data = read_port(rd2_en, rd2_addr);
    end

    assert property (@(posedge clk) disable iff (!arst_n) regs[0] == '0)
        else $error("regfile: r0 holds %h", regs[0]);

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/1ns
`default_nettype none

module id_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              valid,
    input  la_pkg::word_t     pc,
    input  la_pkg::word_t     inst,
    input  logic              pre_taken,
    input  la_pkg::word_t     pre_addr,
    input  logic              stall,
    input  logic              flush,
    input  logic              wb_en,
    input  la_pkg::reg_addr_t wb_addr,
    input  la_pkg::word_t     wb_data,
    output la_pkg::id_ex_t    id_ex
);
    import la_pkg::*;

    dec_bus_t dec;
    logic     ine;
    word_t    reg1_data;
    word_t    reg2_data;
    id_ex_t   ex_next;

    id id_inst (
        .clk    (clk),
        .arst_n (arst_n),
        .inst   (inst),
        .dec    (dec),
        .ine    (ine)
    );

    regfile regfile_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .wb_en    (wb_en),
        .wb_addr  (wb_addr),
        .wb_data  (wb_data),
        .rd1_en   (dec.reg1_read_en),
        .rd2_en   (dec.reg2_read_en),
        .rd1_addr (dec.reg1_addr),
        .rd2_addr (dec.reg2_addr),
        .rd1_data (reg1_data),
        .rd2_data (reg2_data)
    );

    always_comb begin
        ex_next              = '0;
        ex_next.valid        = valid;
        ex_next.ine          = valid && ine;
        ex_next.pc           = pc;
        ex_next.inst         = inst;
        ex_next.reg_write_en = dec.reg_write_en;
        ex_next.aluop        = dec.aluop;
        ex_next.alusel       = dec.alusel;
        ex_next.imm          = dec.imm;
        ex_next.reg1_read_en = dec.reg1_read_en;
        ex_next.reg2_read_en = dec.reg2_read_en;
        ex_next.reg1_addr    = dec.reg1_addr;
        ex_next.reg2_addr    = dec.reg2_addr;
        ex_next.wr_addr      = dec.wr_addr;
        ex_next.reg1_data    = reg1_data;
        ex_next.reg2_data    = reg2_data;
        ex_next.pre_taken    = pre_taken;
        ex_next.pre_addr     = pre_addr;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (flush) begin                           // Flush beats stall
            id_ex.valid <= 1'b0;
            id_ex.ine   <= 1'b0;
        end else if (!stall) begin
            id_ex <= ex_next;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) flush |=> !id_ex.valid)
        else $error("id_stage: valid still high after flush");

endmodule

`default_nettype wire

// File: test/tb_id_stage.sv
`timescale 1ns/1ns
`default_nettype none

`include "la_settings.svh"

module tb_id_stage;
    import la_pkg::*;

    localparam logic [16:0] op_3r [7] = '{`LA_OP_ADD_W, `LA_OP_SUB_W, `LA_OP_SLT,
        `LA_OP_SLTU, `LA_OP_AND, `LA_OP_OR, `LA_OP_XOR};
    localparam aluop_t alu_3r [7] = '{`LA_ALUOP_ADD, `LA_ALUOP_SUB, `LA_ALUOP_SLT,
        `LA_ALUOP_SLTU, `LA_ALUOP_AND, `LA_ALUOP_OR, `LA_ALUOP_XOR};
    localparam logic [9:0] op_2ri12 [8] = '{`LA_OP_SLTI, `LA_OP_SLTUI, `LA_OP_ADDI_W,
        `LA_OP_ANDI, `LA_OP_ORI, `LA_OP_XORI, `LA_OP_LD_W, `LA_OP_ST_W};
    localparam aluop_t alu_2ri12 [8] = '{`LA_ALUOP_SLT, `LA_ALUOP_SLTU, `LA_ALUOP_ADD,
        `LA_ALUOP_AND, `LA_ALUOP_OR, `LA_ALUOP_XOR, `LA_ALUOP_LD, `LA_ALUOP_ST};
    localparam alusel_t sel_2ri12 [8] = '{`LA_ALUSEL_ARITH, `LA_ALUSEL_ARITH,
        `LA_ALUSEL_ARITH, `LA_ALUSEL_LOGIC, `LA_ALUSEL_LOGIC, `LA_ALUSEL_LOGIC,
        `LA_ALUSEL_MEM, `LA_ALUSEL_MEM};
    localparam logic [6:0] op_1ri20 [2] = '{`LA_OP_LU12I_W, `LA_OP_PCADDU12I};
    localparam aluop_t alu_1ri20 [2] = '{`LA_ALUOP_LUI, `LA_ALUOP_PCADD};

    logic      clk;
    logic      arst_n;
    logic      valid;
    word_t     pc;
    word_t     inst;
    logic      pre_taken;
    word_t     pre_addr;
    logic      stall;
    logic      flush;
    logic      wb_en;
    reg_addr_t wb_addr;
    word_t     wb_data;
    id_ex_t    id_ex;

    word_t       shadow [`LA_NUM_REGS];                     // Register file model
    id_ex_t      last_expected;                             // Model word of the last issue
    logic [31:0] lcg_state;
    int          checks;
    int          errors;
    int          test_errors;

    id_stage id_stage_inst (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid     (valid),
        .pc        (pc),
        .inst      (inst),
        .pre_taken (pre_taken),
        .pre_addr  (pre_addr),
        .stall     (stall),
        .flush     (flush),
        .wb_en     (wb_en),
        .wb_addr   (wb_addr),
        .wb_data   (wb_data),
        .id_ex     (id_ex)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic reg_addr_t rand_reg();
        word_t r;
        r = next_rand();
        return r[20:16];                                    // High bits, better period
    endfunction

    function automatic word_t read_model(input logic en, input reg_addr_t a, input logic we,
            input reg_addr_t wa, input word_t wd);
        if (!en || a == '0) return '0;
        if (we && wa == a) return wd;
        return shadow[a];
    endfunction

    function automatic id_ex_t reference_decode(input logic v, input word_t p, input word_t i,
            input logic pt, input word_t pa, input logic we, input reg_addr_t wa,
            input word_t wd);
        id_ex_t e;
        e           = '0;
        e.valid     = v;
        e.ine       = v;                                    // Cleared below on a match
        e.pc        = p;
        e.inst      = i;
        e.pre_taken = pt;
        e.pre_addr  = pa;
        for (int k = 0; k < 7; k++) begin
            if (i[31:15] == op_3r[k]) begin
                e.ine          = 1'b0;
                e.aluop        = alu_3r[k];
                e.alusel       = (k < 4) ? `LA_ALUSEL_ARITH : `LA_ALUSEL_LOGIC;
                e.reg_write_en = 1'b1;
                e.reg1_read_en = 1'b1;
                e.reg2_read_en = 1'b1;
                e.reg1_addr    = i[9:5];
                e.reg2_addr    = i[14:10];
                e.wr_addr      = i[4:0];
            end
        end
        for (int k = 0; k < 8; k++) begin
            if (i[31:22] == op_2ri12[k]) begin
                e.ine          = 1'b0;
                e.aluop        = alu_2ri12[k];
                e.alusel       = sel_2ri12[k];
                e.imm          = (sel_2ri12[k] == `LA_ALUSEL_LOGIC) ?
                                 {20'h0, i[21:10]} : {{20{i[21]}}, i[21:10]};
                e.reg1_read_en = 1'b1;
                e.reg1_addr    = i[9:5];
                if (k == 7) begin                           // st.w reads rd
                    e.reg2_read_en = 1'b1;
                    e.reg2_addr    = i[4:0];
                end else begin
                    e.reg_write_en = 1'b1;
                    e.wr_addr      = i[4:0];
                end
            end
        end
        for (int k = 0; k < 2; k++) begin
            if (i[31:25] == op_1ri20[k]) begin
                e.ine          = 1'b0;
                e.aluop        = alu_1ri20[k];
                e.alusel       = `LA_ALUSEL_IMM;
                e.imm          = {i[24:5], 12'h0};
                e.reg_write_en = 1'b1;
                e.wr_addr      = i[4:0];
            end
        end
        e.reg1_data = read_model(e.reg1_read_en, e.reg1_addr, we, wa, wd);
        e.reg2_data = read_model(e.reg2_read_en, e.reg2_addr, we, wa, wd);
        return e;
    endfunction

    task automatic check_field(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            $display("ERROR %s: got %h, expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_hold(input id_ex_t held);
        checks++;
        assert (id_ex === held) else begin
            $display("ERROR id_ex: got %h, expected %h", id_ex, held);
            test_errors++;
        end
    endtask

    task automatic compare_output(input id_ex_t e);
        check_field("valid", 32'(id_ex.valid), 32'(e.valid));
        if (e.valid) begin
            check_field("ine", 32'(id_ex.ine), 32'(e.ine));
            check_field("pc", id_ex.pc, e.pc);
            check_field("inst", id_ex.inst, e.inst);
            check_field("pre_taken", 32'(id_ex.pre_taken), 32'(e.pre_taken));
            check_field("pre_addr", id_ex.pre_addr, e.pre_addr);
            check_field("aluop", 32'(id_ex.aluop), 32'(e.aluop));
            check_field("alusel", 32'(id_ex.alusel), 32'(e.alusel));
            check_field("imm", id_ex.imm, e.imm);
            check_field("reg_write_en", 32'(id_ex.reg_write_en), 32'(e.reg_write_en));
            check_field("reg1_read_en", 32'(id_ex.reg1_read_en), 32'(e.reg1_read_en));
            check_field("reg2_read_en", 32'(id_ex.reg2_read_en), 32'(e.reg2_read_en));
            if (e.reg1_read_en) check_field("reg1_addr", 32'(id_ex.reg1_addr), 32'(e.reg1_addr));
            if (e.reg2_read_en) check_field("reg2_addr", 32'(id_ex.reg2_addr), 32'(e.reg2_addr));
            if (e.reg_write_en) check_field("wr_addr", 32'(id_ex.wr_addr), 32'(e.wr_addr));
            check_field("reg1_data", id_ex.reg1_data, e.reg1_data);
            check_field("reg2_data", id_ex.reg2_data, e.reg2_data);
        end
    endtask

    // Drive one instruction and write-back strobe, check id_ex one cycle later
    task automatic issue(input logic v, input word_t instr, input logic we,
            input reg_addr_t wa, input word_t wd);
        word_t  p;
        word_t  pa;
        word_t  r;
        id_ex_t e;
        p = next_rand();
        pa = next_rand();
        r = next_rand();
        e = reference_decode(v, p, instr, r[24], pa, we, wa, wd);
        last_expected = e;
        @(posedge clk);
        valid     <= v;
        pc        <= p;
        inst      <= instr;
        pre_taken <= r[24];
        pre_addr  <= pa;
        wb_en     <= we;
        wb_addr   <= wa;
        wb_data   <= wd;
        @(posedge clk);
        wb_en <= 1'b0;
        if (we && wa != '0) shadow[wa] = wd;
        @(negedge clk);
        compare_output(e);
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d errors", name, test_errors);
        errors += test_errors;
        test_errors = 0;
    endtask

    task automatic regfile_access();
        reg_addr_t a;
        for (int n = 0; n < 12; n++) begin
            issue(1'b0, next_rand(), 1'b1, rand_reg(), next_rand());
        end
        for (int n = 0; n < 12; n++) begin
            issue(1'b1, {`LA_OP_OR, rand_reg(), rand_reg(), rand_reg()}, 1'b0, '0, '0);
        end
        issue(1'b1, {`LA_OP_ADD_W, 5'd0, 5'd0, 5'd1}, 1'b1, 5'd0, next_rand());  // r0 write
        issue(1'b1, {`LA_OP_ADD_W, 5'd0, 5'd0, 5'd1}, 1'b0, '0, '0);
        a = rand_reg() | 5'd1;
        issue(1'b1, {`LA_OP_XOR, a, a, 5'd2}, 1'b1, a, next_rand());          // Bypass
        finish_test("regfile access");
    endtask

    task automatic decode_3r();
        for (int k = 0; k < 7; k++) begin
            for (int n = 0; n < 2; n++) begin
                issue(1'b1, {op_3r[k], rand_reg(), rand_reg(), rand_reg()}, 1'b1,
                      rand_reg(), next_rand());
            end
        end
        finish_test("3R decode");
    endtask

    task automatic decode_2ri12();
        word_t       r;
        logic [11:0] imm;
        for (int k = 0; k < 8; k++) begin
            for (int n = 0; n < 2; n++) begin
                r = next_rand();
                imm = r[27:16];
                imm[11] = (n == 1);                         // Both signs of the immediate
                issue(1'b1, {op_2ri12[k], imm, rand_reg(), rand_reg()}, 1'b0, '0, '0);
            end
        end
        finish_test("2RI12 decode");
    endtask

    task automatic decode_1ri20();
        word_t r;
        for (int k = 0; k < 2; k++) begin
            for (int n = 0; n < 3; n++) begin
                r = next_rand();
                issue(1'b1, {op_1ri20[k], r[31:12], rand_reg()}, 1'b0, '0, '0);
            end
        end
        finish_test("1RI20 decode");
    endtask

    task automatic invalid_inst();
        word_t r;
        r = next_rand();
        issue(1'b1, 32'hffff_ffff, 1'b0, '0, '0);
        issue(1'b1, 32'h0000_0000, 1'b0, '0, '0);
        issue(1'b1, {10'h0a7, r[21:0]}, 1'b0, '0, '0);
        issue(1'b0, {op_3r[0], rand_reg(), rand_reg(), rand_reg()}, 1'b0, '0, '0);
        finish_test("invalid instruction");
    endtask

    task automatic stall_and_flush();
        id_ex_t held;
        issue(1'b1, {op_3r[0], rand_reg(), rand_reg(), rand_reg()}, 1'b0, '0, '0);
        held = last_expected;
        @(posedge clk);
        stall <= 1'b1;
        @(negedge clk);
        check_hold(held);
        for (int n = 0; n < 3; n++) begin
            @(posedge clk);
            pc       <= next_rand();
            inst     <= {op_2ri12[n], 12'h5a5, rand_reg(), rand_reg()};
            pre_addr <= next_rand();
            @(negedge clk);
            check_hold(held);
        end
        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b1;
        @(posedge clk);
        flush <= 1'b0;
        @(negedge clk);
        check_field("valid after flush", 32'(id_ex.valid), 32'h0);
        issue(1'b1, {op_3r[1], rand_reg(), rand_reg(), rand_reg()}, 1'b0, '0, '0);
        @(posedge clk);
        stall <= 1'b1;
        flush <= 1'b1;
        @(posedge clk);
        stall <= 1'b0;
        flush <= 1'b0;
        @(negedge clk);
        check_field("valid after flush and stall", 32'(id_ex.valid), 32'h0);
        finish_test("stall and flush");
    endtask

    initial begin
        repeat (5000) @(posedge clk);
        $display("Timeout: the tests did not finish within 5000 cycles");
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        lcg_state   = 32'h7f16;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        arst_n      = 1'b0;
        valid       = 1'b0;
        pc          = '0;
        inst        = '0;
        pre_taken   = 1'b0;
        pre_addr    = '0;
        stall       = 1'b0;
        flush       = 1'b0;
        wb_en       = 1'b0;
        wb_addr     = '0;
        wb_data     = '0;
        for (int i = 0; i < `LA_NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        regfile_access();
        decode_3r();
        decode_2ri12();
        decode_1ri20();
        invalid_inst();
        stall_and_flush();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+hw
hw/la_pkg.sv
hw/id_fmt_3r.sv
hw/id_fmt_2ri12.sv
hw/id_fmt_1ri20.sv
hw/id.sv
hw/regfile.sv
hw/id_stage.sv
test/tb_id_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_id_stage
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= TESTBENCH PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
